/* compile.f */
+incdir+test
hw/cp0Pkg.sv
hw/exceptionCommitIf.sv
hw/exceptionArbiter.sv
hw/cp0Timer.sv
hw/cp0RegisterFile.sv
hw/coprocessorZero.sv
test/coprocessorZeroTb.sv

/* test/cp0TbCases.svh */
`ifndef CP0_TB_CASES_SVH
`define CP0_TB_CASES_SVH

// Pipeline values held for the whole run
localparam wordT idPc         = 32'h0000_1004;
localparam wordT exPc         = 32'h0000_1008;
localparam wordT memPc        = 32'h0000_100C;
localparam wordT memBadAddr   = 32'h0000_0FF3;   // Unaligned load address
localparam wordT fetchBadAddr = 32'h0000_2002;

// Op bits are skip-read-check, mfc0, mtc0 and eret
localparam logic [3:0] opIdle  = 4'b0000;
localparam logic [3:0] opRead  = 4'b0100;
localparam logic [3:0] opPeek  = 4'b1100;   // mfc0 with a free-running result
localparam logic [3:0] opWrite = 4'b0010;
localparam logic [3:0] opEret  = 4'b0001;

// Fault bits are excAdEL, excSys and mCanErr
localparam logic [2:0] noFault    = 3'b000;
localparam logic [2:0] loadAndSys = 3'b110;   // MEM and ID fault together
localparam logic [2:0] sysMemBusy = 3'b011;   // ID fault behind a busy MEM

typedef struct packed {
    logic [3:0] op;
    logic [2:0] fault;
    regAddrT    addr;
    wordT       data;
    logic [3:0] flush;      // mFlush, exFlush, idFlush, ifFlush
    logic [3:0] stall;      // mStallExc, exStallExc, idStallExc, ifStallExc
    logic       select;     // Expected excPcSelect, excPc checked only when set
    wordT       pc;
    wordT       read;
    logic       kernel;     // Expected kernelMode
} rowT;

// Expected Cause word, BD clear
function automatic wordT causeValue(excCodeT code, logic [7:0] pending);
    wordT value;
    value = '0;
    value[causeIpLsb +: 8] = pending;
    value[causeExcLsb +: 5] = code;
    return value;
endfunction

localparam int timerWaitRow = 22;   // Timer wait runs before this row
localparam int rowCount = 28;

localparam rowT caseTable [rowCount] = '{
    '{opWrite, noFault, regCompare, 32'h0000_1000, 4'b0000, 4'b0000, 1'b0, '0, '0, 1'b1},
    '{opRead, noFault, regCompare, '0, 4'b0000, 4'b0000, 1'b0, '0, 32'h0000_1000, 1'b1},
    '{opPeek, noFault, regCount, '0, 4'b0000, 4'b0000, 1'b0, '0, '0, 1'b1},   // Acks IP7
    '{opWrite, noFault, regStatus, 32'h0040_8000, 4'b0000, 4'b0000, 1'b0, '0, '0, 1'b1},
    '{opRead, noFault, regStatus, '0, 4'b0000, 4'b0000, 1'b0, '0, 32'h0040_8000, 1'b1},
    '{opWrite, noFault, regEpc, 32'h0000_2000, 4'b0000, 4'b0000, 1'b0, '0, '0, 1'b1},
    '{opRead, noFault, regEpc, '0, 4'b0000, 4'b0000, 1'b0, '0, 32'h0000_2000, 1'b1},
    '{opRead, noFault, regPrid, '0, 4'b0000, 4'b0000, 1'b0, '0, 32'h0000_0001, 1'b1},
    '{opRead, noFault, regConfig, '0, 4'b0000, 4'b0000, 1'b0, '0, configValue, 1'b1},
    '{opRead, noFault, 5'd3, '0, 4'b0000, 4'b0000, 1'b0, '0, '0, 1'b1},
    // MEM AdEL beats ID Sys
    '{opIdle, loadAndSys, 5'd0, '0, 4'b1111, 4'b0000, 1'b1, vectorBootGeneral, '0, 1'b1},
    '{opRead, noFault, regCause, '0, 4'b0000, 4'b0000, 1'b0, '0,
      causeValue(cp0Pkg::excAdEL, 8'h00), 1'b1},
    '{opRead, noFault, regEpc, '0, 4'b0000, 4'b0000, 1'b0, '0, memPc, 1'b1},
    '{opRead, noFault, regBadVAddr, '0, 4'b0000, 4'b0000, 1'b0, '0, memBadAddr, 1'b1},
    // Sys held while MEM can still fault
    '{opIdle, sysMemBusy, 5'd0, '0, 4'b0011, 4'b0010, 1'b0, '0, '0, 1'b1},
    '{opRead, noFault, regCause, '0, 4'b0000, 4'b0000, 1'b0, '0,
      causeValue(cp0Pkg::excAdEL, 8'h00), 1'b1},
    '{opRead, noFault, regEpc, '0, 4'b0000, 4'b0000, 1'b0, '0, memPc, 1'b1},
    '{opEret, noFault, 5'd0, '0, 4'b0001, 4'b0000, 1'b1, memPc, '0, 1'b1},
    '{opRead, noFault, regStatus, '0, 4'b0000, 4'b0000, 1'b0, '0, 32'h0040_8000, 1'b1},
    // Normal vectors, IE and IM7 on, timer restarted
    '{opWrite, noFault, regStatus, 32'h0000_8001, 4'b0000, 4'b0000, 1'b0, '0, '0, 1'b1},
    '{opWrite, noFault, regCount, 32'h0000_0000, 4'b0000, 4'b0000, 1'b0, '0, '0, 1'b1},
    '{opWrite, noFault, regCompare, 32'd20, 4'b0000, 4'b0000, 1'b0, '0, '0, 1'b1},
    '{opIdle, noFault, 5'd0, '0, 4'b0011, 4'b0000, 1'b1, vectorNormalGeneral, '0, 1'b1},
    '{opRead, noFault, regCause, '0, 4'b0000, 4'b0000, 1'b0, '0, causeValue(excInt, 8'h80), 1'b1},
    '{opRead, noFault, regEpc, '0, 4'b0000, 4'b0000, 1'b0, '0, idPc, 1'b1},
    // User mode, EXL and CU0 clear
    '{opWrite, noFault, regStatus, 32'h0000_0010, 4'b0000, 4'b0000, 1'b0, '0, '0, 1'b1},
    '{opRead, noFault, regStatus, '0, 4'b0011, 4'b0000, 1'b1, vectorNormalGeneral, '0, 1'b0},
    '{opRead, noFault, regCause, '0, 4'b0000, 4'b0000, 1'b0, '0, causeValue(excCpU, 8'h80), 1'b1}
};

`endif

/* test/coprocessorZeroTb.sv */
`timescale 1ns/10ps
`default_nettype none

module coprocessorZeroTb
    import cp0Pkg::*;
();

`include "cp0TbCases.svh"

    localparam int timerTimeout = 100;   // Cycles allowed for the Compare match

    logic       clock, reset;
    logic       mfc0, mtc0, eret, cop1;
    logic       ifStall, idStall, idIsFlushed;
    regAddrT    regAddr;
    selectT     regSelect;
    wordT       writeData, readData;
    logic       kernelMode;
    logic [4:0] interrupts;
    logic       excAdIF, excAdEL, excAdES, excOv, excTr, excSys, excBp, excRI;
    wordT       idRestartPc, exRestartPc, mRestartPc;
    logic       ifIsBD, idIsBD, exIsBD, mIsBD;
    wordT       badAddrM, badAddrIF;
    logic       idCanErr, exCanErr, mCanErr;
    logic       ifStallExc, idStallExc, exStallExc, mStallExc;
    logic       ifFlush, idFlush, exFlush, mFlush;
    logic       excPcSelect;
    wordT       excPc;
    logic [7:0] pendingInterrupts;

    coprocessorZero #(.revision(8'd1)) dut_i (
        .clock, .reset, .mfc0, .mtc0, .eret, .cop1, .ifStall, .idStall, .idIsFlushed,
        .regAddr, .regSelect, .writeData, .readData, .kernelMode, .interrupts,
        .excAdIF, .excAdEL, .excAdES, .excOv, .excTr, .excSys, .excBp, .excRI,
        .idRestartPc, .exRestartPc, .mRestartPc, .ifIsBD, .idIsBD, .exIsBD, .mIsBD,
        .badAddrM, .badAddrIF, .idCanErr, .exCanErr, .mCanErr,
        .ifStallExc, .idStallExc, .exStallExc, .mStallExc,
        .ifFlush, .idFlush, .exFlush, .mFlush,
        .excPcSelect, .excPc, .pendingInterrupts
    );

    always #2 clock = ~clock;   // 4 ns period

    task automatic compareWord(string name, wordT expected, wordT actual);
        if (actual !== expected) begin
            $display("[FAIL] time %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Word mismatch on %s", name);
        end
    endtask

    task automatic flagEquals(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("[FAIL] time %0t %s expected %b actual %b", $time, name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Flag mismatch on %s", name);
        end
    endtask

    // Only the row's own controls change, the pipeline context stays put
    task automatic applyRow(rowT row);
        mfc0      = row.op[2];
        mtc0      = row.op[1];
        eret      = row.op[0];
        excAdEL   = row.fault[2];
        excSys    = row.fault[1];
        mCanErr   = row.fault[0];
        regAddr   = row.addr;
        regSelect = 3'd0;
        writeData = row.data;
        idStall   = 1'b0;
    endtask

    task automatic verifyRow(int index, rowT row);
        string tag;
        tag = $sformatf("row %0d ", index);
        flagEquals({tag, "mFlush"}, row.flush[3], mFlush);
        flagEquals({tag, "exFlush"}, row.flush[2], exFlush);
        flagEquals({tag, "idFlush"}, row.flush[1], idFlush);
        flagEquals({tag, "ifFlush"}, row.flush[0], ifFlush);
        flagEquals({tag, "mStallExc"}, row.stall[3], mStallExc);
        flagEquals({tag, "exStallExc"}, row.stall[2], exStallExc);
        flagEquals({tag, "idStallExc"}, row.stall[1], idStallExc);
        flagEquals({tag, "ifStallExc"}, row.stall[0], ifStallExc);
        flagEquals({tag, "excPcSelect"}, row.select, excPcSelect);
        flagEquals({tag, "kernelMode"}, row.kernel, kernelMode);
        if (row.select) compareWord({tag, "excPc"}, row.pc, excPc);
        if (!row.op[3]) compareWord({tag, "readData"}, row.read, readData);   // Skip Count value
    endtask

    // ID held so the timer interrupt cannot commit while waiting
    task automatic waitForTimer();
        int cycles;
        for (cycles = 0; cycles < timerTimeout; cycles++) begin
            @(posedge clock);
            #1;
            applyRow('0);
            idStall = 1'b1;
            #2;
            if (pendingInterrupts[7]) return;
        end
        $display("Timer interrupt IP7 did not rise within %0d cycles", timerTimeout);
        $display("TESTS FAILED");
        $fatal(1, "Timer wait timed out");
    endtask

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        applyRow('0);
        cop1        = 1'b0;
        ifStall     = 1'b0;
        idIsFlushed = 1'b0;
        interrupts  = '0;
        excAdIF     = 1'b0;
        excAdES     = 1'b0;
        excOv       = 1'b0;
        excTr       = 1'b0;
        excBp       = 1'b0;
        excRI       = 1'b0;
        idRestartPc = idPc;
        exRestartPc = exPc;
        mRestartPc  = memPc;
        ifIsBD      = 1'b0;
        idIsBD      = 1'b0;
        exIsBD      = 1'b0;
        mIsBD       = 1'b0;
        badAddrM    = memBadAddr;
        badAddrIF   = fetchBadAddr;
        idCanErr    = 1'b0;
        exCanErr    = 1'b0;

        // Reset vector while reset is held
        @(posedge clock);
        #1;
        flagEquals("excPcSelect", 1'b1, excPcSelect);
        compareWord("excPc", vectorReset, excPc);
        @(posedge clock);
        #1;
        reset = 1'b0;   // Two cycles of reset
        #1;
        flagEquals("ifFlush", 1'b1, ifFlush);   // First cycle after reset

        for (int i = 0; i < rowCount; i++) begin
            if (i == timerWaitRow) waitForTimer();
            @(posedge clock);
            #1;
            applyRow(caseTable[i]);
            #2;                 // Sample before the next edge
            verifyRow(i, caseTable[i]);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/coprocessorZero.sv */
`timescale 1ns/10ps
`default_nettype none

module coprocessorZero
    import cp0Pkg::*;
#(
    parameter logic [7:0] revision = 8'd1
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       mfc0,
    input  logic       mtc0,
    input  logic       eret,
    input  logic       cop1,
    input  logic       ifStall,
    input  logic       idStall,
    input  logic       idIsFlushed,
    input  regAddrT    regAddr,
    input  selectT     regSelect,
    input  wordT       writeData,
    output wordT       readData,
    output logic       kernelMode,
    input  logic [4:0] interrupts,
    input  logic       excAdIF,
    input  logic       excAdEL,
    input  logic       excAdES,
    input  logic       excOv,
    input  logic       excTr,
    input  logic       excSys,
    input  logic       excBp,
    input  logic       excRI,
    input  wordT       idRestartPc,
    input  wordT       exRestartPc,
    input  wordT       mRestartPc,
    input  logic       ifIsBD,
    input  logic       idIsBD,
    input  logic       exIsBD,
    input  logic       mIsBD,
    input  wordT       badAddrM,
    input  wordT       badAddrIF,
    input  logic       idCanErr,
    input  logic       exCanErr,
    input  logic       mCanErr,
    output logic       ifStallExc,
    output logic       idStallExc,
    output logic       exStallExc,
    output logic       mStallExc,
    output logic       ifFlush,
    output logic       idFlush,
    output logic       exFlush,
    output logic       mFlush,
    output logic       excPcSelect,
    output wordT       excPc,
    output logic [7:0] pendingInterrupts
);

    exceptionCommitIf commitBus ();

    logic countWrite, compareWrite, timerMatch;
    wordT count, compare;
    logic arbiterIfFlush;
    logic resetDelayed;     // High for the first cycle after reset

    // Fetch restarts cleanly from the reset vector
    always_ff @(posedge clock) begin
        resetDelayed <= reset;
    end

    assign ifFlush = arbiterIfFlush | resetDelayed;

    exceptionArbiter arbiter_i (
        .mfc0, .mtc0, .eret, .cop1, .ifStall, .idStall, .idIsFlushed,
        .excAdIF, .excAdEL, .excAdES, .excOv, .excTr, .excSys, .excBp, .excRI,
        .idCanErr, .exCanErr, .mCanErr,
        .ifStallExc, .idStallExc, .exStallExc, .mStallExc,
        .ifFlush(arbiterIfFlush), .idFlush, .exFlush, .mFlush,
        .commit(commitBus.arbiter)
    );

    cp0Timer timer_i (
        .clock, .reset, .countWrite, .compareWrite, .writeData,
        .count, .compare, .timerMatch
    );

    cp0RegisterFile #(.revision(revision)) registers_i (
        .clock, .reset, .mfc0, .mtc0, .eret, .idStall,
        .regAddr, .regSelect, .writeData, .interrupts,
        .idRestartPc, .exRestartPc, .mRestartPc,
        .ifIsBD, .idIsBD, .exIsBD, .mIsBD, .badAddrM, .badAddrIF,
        .countWrite, .compareWrite, .count, .compare, .timerMatch,
        .commit(commitBus.registers),
        .readData, .excPc, .excPcSelect, .kernelMode, .pendingInterrupts
    );

endmodule

`default_nettype wire

/* hw/cp0RegisterFile.sv */
`timescale 1ns/10ps
`default_nettype none

module cp0RegisterFile
    import cp0Pkg::*;
#(
    parameter logic [7:0] revision = 8'd1   // PRId revision field
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       mfc0,
    input  logic       mtc0,
    input  logic       eret,
    input  logic       idStall,
    input  regAddrT    regAddr,
    input  selectT     regSelect,
    input  wordT       writeData,
    input  logic [4:0] interrupts,          // External lines into IP6..IP2
    input  wordT       idRestartPc,
    input  wordT       exRestartPc,
    input  wordT       mRestartPc,
    input  logic       ifIsBD,
    input  logic       idIsBD,
    input  logic       exIsBD,
    input  logic       mIsBD,
    input  wordT       badAddrM,
    input  wordT       badAddrIF,
    output logic       countWrite,
    output logic       compareWrite,
    input  wordT       count,
    input  wordT       compare,
    input  logic       timerMatch,
    exceptionCommitIf.registers commit,
    output wordT       readData,
    output wordT       excPc,
    output logic       excPcSelect,
    output logic       kernelMode,
    output logic [7:0] pendingInterrupts
);

    // Status fields
    logic       statusCu0;
    logic       statusBev;
    logic [7:0] statusIm;
    logic       statusUm;
    logic       statusExl;
    logic       statusIe;

    // Cause fields
    logic       causeBd;
    logic [7:0] causeIp;
    excCodeT    causeExcCode;

    wordT epc;
    wordT badVAddr;
    wordT statusWord, causeWord, pridWord;
    wordT stagePc;              // Restart PC of the committing stage
    logic stageBd;
    logic writeEnable;
    logic statusWrite, causeWrite, epcWrite;
    logic countRead;
    logic eretTaken;

    assign kernelMode         = ~statusUm | statusExl;
    assign commit.cp0Usable   = statusCu0 | kernelMode;
    assign pendingInterrupts  = causeIp;
    assign commit.interruptRequest = statusIe & ~statusExl & (|(causeIp & statusIm));

    // mtc0 decode, held back while ID stalls
    assign writeEnable  = commit.cp0Usable & mtc0 & ~idStall & (regSelect == 3'd0);
    assign statusWrite  = writeEnable & (regAddr == regStatus);
    assign causeWrite   = writeEnable & (regAddr == regCause);
    assign epcWrite     = writeEnable & (regAddr == regEpc);
    assign countWrite   = writeEnable & (regAddr == regCount);
    assign compareWrite = writeEnable & (regAddr == regCompare);

    // Reading Count acknowledges the timer interrupt
    assign countRead = commit.cp0Usable & mfc0 & (regAddr == regCount) & (regSelect == 3'd0);
    assign eretTaken = eret & ~idStall;

    always_comb begin
        statusWord = '0;
        statusWord[statusCu0Bit] = statusCu0;
        statusWord[statusBevBit] = statusBev;
        statusWord[statusImLsb +: 8] = statusIm;
        statusWord[statusUmBit] = statusUm;
        statusWord[statusExlBit] = statusExl;
        statusWord[statusIeBit] = statusIe;
        causeWord = '0;
        causeWord[causeBdBit] = causeBd;
        causeWord[causeIpLsb +: 8] = causeIp;
        causeWord[causeExcLsb +: 5] = causeExcCode;
    end

    assign pridWord = {24'h00_0000, revision};   // No company or processor ID

    // mfc0 read mux, zero without access rights
    always_comb begin
        readData = '0;
        if (mfc0 && commit.cp0Usable && regSelect == 3'd0) begin
            case (regAddr)
                regBadVAddr: readData = badVAddr;
                regCount:    readData = count;
                regCompare:  readData = compare;
                regStatus:   readData = statusWord;
                regCause:    readData = causeWord;
                regEpc:      readData = epc;
                regPrid:     readData = pridWord;
                regConfig:   readData = configValue;
                default:     readData = '0;
            endcase
        end
    end

    always_comb begin
        case (commit.commitStage)
            stageMEM: begin
                stagePc = mRestartPc;
                stageBd = mIsBD;
            end
            stageEX: begin
                stagePc = exRestartPc;
                stageBd = exIsBD;
            end
            stageID: begin
                stagePc = idRestartPc;
                stageBd = idIsBD;
            end
            default: begin
                stagePc = badAddrIF;    // Fetch faults restart at the bad PC
                stageBd = ifIsBD;
            end
        endcase
    end

    // Mode and mask bits
    always_ff @(posedge clock) begin
        if (reset) begin
            statusCu0 <= 1'b0;
            statusBev <= 1'b1;          // Boot vectors after reset
            statusIm  <= '0;
            statusUm  <= 1'b0;          // Kernel mode after reset
            statusIe  <= 1'b0;
        end else if (statusWrite) begin
            statusCu0 <= writeData[statusCu0Bit];
            statusBev <= writeData[statusBevBit];
            statusIm  <= writeData[statusImLsb +: 8];
            statusUm  <= writeData[statusUmBit];
            statusIe  <= writeData[statusIeBit];
        end
    end

    // Exception level, code and branch delay flag
    always_ff @(posedge clock) begin
        if (reset) begin
            statusExl    <= 1'b0;
            causeBd      <= 1'b0;
            causeExcCode <= excInt;
        end else if (commit.commitValid) begin
            statusExl    <= 1'b1;
            causeExcCode <= commit.commitCode;
            if (!statusExl) causeBd <= stageBd;   // Nested exceptions keep the first BD
        end else if (statusWrite) begin
            statusExl <= writeData[statusExlBit];
        end else if (eretTaken) begin
            statusExl <= 1'b0;
        end
    end

    // Pending interrupts
    always_ff @(posedge clock) begin
        if (reset) begin
            causeIp <= '0;
        end else begin
            causeIp[7]   <= countRead ? 1'b0 : (causeIp[7] | timerMatch);    // Sticky timer bit
            causeIp[6:2] <= interrupts;
            if (causeWrite) causeIp[1:0] <= writeData[causeIpLsb +: 2];    // Software interrupts
        end
    end

    // Exception payload
    always_ff @(posedge clock) begin
        if (commit.commitValid) begin
            if (!statusExl) epc <= stagePc;
            if (commit.commitStage == stageMEM) badVAddr <= badAddrM;
            else if (commit.commitStage == stageIF) badVAddr <= badAddrIF;
        end else if (epcWrite) begin
            epc <= writeData;
        end
    end

    assign excPcSelect = reset | eretTaken | commit.commitValid;

    // Redirect target
    always_comb begin
        if (reset) excPc = vectorReset;
        else if (eretTaken) excPc = epc;
        else if (statusBev) excPc = vectorBootGeneral;
        else excPc = vectorNormalGeneral;
    end

endmodule

`default_nettype wire

/* hw/cp0Timer.sv */
`timescale 1ns/10ps
`default_nettype none

module cp0Timer
    import cp0Pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic countWrite,    // mtc0 to Count
    input  logic compareWrite,  // mtc0 to Compare
    input  wordT writeData,
    output wordT count,
    output wordT compare,
    output logic timerMatch     // Raises IP7 in the register file
);

    assign timerMatch = (count == compare);

    // Software write first, then wrap on match, else count up
    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (countWrite) begin
            count <= writeData;
        end else if (timerMatch) begin
            count <= '0;     // Wrap to zero on match
        end else begin
            count <= count + 32'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            compare <= '0;
        end else if (compareWrite) begin
            compare <= writeData;
        end
    end

endmodule

`default_nettype wire

/* hw/exceptionArbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module exceptionArbiter
    import cp0Pkg::*;
(
    input  logic mfc0,
    input  logic mtc0,
    input  logic eret,
    input  logic cop1,          // Instruction targets coprocessor 1
    input  logic ifStall,
    input  logic idStall,       // No commit while ID is held
    input  logic idIsFlushed,   // ID slot holds a bubble
    input  logic excAdIF,
    input  logic excAdEL,
    input  logic excAdES,
    input  logic excOv,
    input  logic excTr,
    input  logic excSys,
    input  logic excBp,
    input  logic excRI,
    input  logic idCanErr,      // ID or any later stage may still fault
    input  logic exCanErr,      // EX or MEM may still fault
    input  logic mCanErr,
    output logic ifStallExc,
    output logic idStallExc,
    output logic exStallExc,
    output logic mStallExc,
    output logic ifFlush,
    output logic idFlush,
    output logic exFlush,
    output logic mFlush,
    exceptionCommitIf.arbiter commit
);

    logic excCpU;
    logic excIntr;
    logic mDetect, exDetect, idDetect, ifDetect;
    logic mMask, exMask, idMask, ifMask;
    logic mReady, exReady, idReady, ifReady;

    // CP1 always unusable, CP0 only in kernel mode or with CU0
    assign excCpU = cop1 | ((mfc0 | mtc0 | eret) & ~commit.cp0Usable);

    // Interrupts are inserted in ID, never into a bubble
    assign excIntr = commit.interruptRequest & ~idIsFlushed;

    // Detections grouped by the stage that raises them
    assign mDetect  = excAdEL | excAdES | excTr;
    assign exDetect = excOv;
    assign idDetect = excSys | excBp | excRI | excCpU | excIntr;
    assign ifDetect = excAdIF;

    // A stage waits while something ahead of it may still fault
    assign mMask  = ifStall;
    assign exMask = ifStall | mCanErr;
    assign idMask = ifStall | mCanErr | exCanErr;
    assign ifMask = mCanErr | exCanErr | idCanErr | excIntr;   // Interrupt wins over fetch

    // Stall only while no forward stage is faulting itself
    assign mStallExc  = mDetect & mMask;
    assign exStallExc = exDetect & exMask & ~mDetect;
    // CP0 writes and ERET also wait for forward stages to clear
    assign idStallExc = (idDetect | eret | mtc0) & idMask & ~(exDetect | mDetect);
    assign ifStallExc = ifDetect & ifMask & ~(idDetect | exDetect | mDetect);

    // Ready terms are mutually exclusive through the masks
    assign mReady  = ~idStall & mDetect & ~mMask;
    assign exReady = ~idStall & exDetect & ~exMask;
    assign idReady = ~idStall & idDetect & ~idMask;
    assign ifReady = ~idStall & ifDetect & ~ifMask;

    // A faulting stage flushes itself and everything behind it
    assign mFlush  = mDetect;
    assign exFlush = mDetect | exDetect;
    assign idFlush = mDetect | exDetect | idDetect;
    assign ifFlush = mDetect | exDetect | idDetect | ifDetect | (eret & ~idStall);

    assign commit.commitValid = mReady | exReady | idReady | ifReady;

    // Forward-most ready stage
    always_comb begin
        if (mReady) commit.commitStage = stageMEM;
        else if (exReady) commit.commitStage = stageEX;
        else if (idReady) commit.commitStage = stageID;
        else commit.commitStage = stageIF;
    end

    // Ordered by stage, interrupt last
    always_comb begin
        if (excAdEL) commit.commitCode = cp0Pkg::excAdEL;
        else if (excAdES) commit.commitCode = cp0Pkg::excAdES;
        else if (excTr) commit.commitCode = cp0Pkg::excTr;
        else if (excOv) commit.commitCode = cp0Pkg::excOv;
        else if (excSys) commit.commitCode = cp0Pkg::excSys;
        else if (excBp) commit.commitCode = cp0Pkg::excBp;
        else if (excRI) commit.commitCode = cp0Pkg::excRI;
        else if (excCpU) commit.commitCode = cp0Pkg::excCpU;
        else if (excAdIF) commit.commitCode = cp0Pkg::excAdEL;   // Fetch error reports as AdEL
        else commit.commitCode = excInt;
    end

endmodule

`default_nettype wire

/* hw/exceptionCommitIf.sv */
`timescale 1ns/10ps
`default_nettype none

// Committed exception from the arbiter, mode status back from the register file
interface exceptionCommitIf
    import cp0Pkg::*;
();

    logic    commitValid;       // One exception commits at the next edge
    stageT   commitStage;       // Forward-most ready stage
    excCodeT commitCode;        // Prioritized ExcCode
    logic    interruptRequest;  // Enabled pending interrupt with EXL clear
    logic    cp0Usable;         // CU0 or kernel mode

    modport arbiter (
        output commitValid,
        output commitStage,
        output commitCode,
        input  interruptRequest,
        input  cp0Usable
    );

    modport registers (
        input  commitValid,
        input  commitStage,
        input  commitCode,
        output interruptRequest,
        output cp0Usable
    );

endinterface

`default_nettype wire

/* hw/cp0Pkg.sv */
`default_nettype none

package cp0Pkg;

    typedef logic [31:0] wordT;     // Data or address word
    typedef logic [4:0]  regAddrT;  // CP0 register number (rd field)
    typedef logic [2:0]  selectT;   // Register select (sel field)

    // Cause.ExcCode values
    typedef enum logic [4:0] {
        excInt  = 5'd0,
        excAdEL = 5'd4,   // Load or fetch address error
        excAdES = 5'd5,   // Store address error
        excSys  = 5'd8,
        excBp   = 5'd9,
        excRI   = 5'd10,  // Reserved instruction
        excCpU  = 5'd11,  // Coprocessor unusable
        excOv   = 5'd12,
        excTr   = 5'd13
    } excCodeT;

    // Pipeline stage that raised the committing exception
    typedef enum logic [1:0] {
        stageIF,
        stageID,
        stageEX,
        stageMEM
    } stageT;

    // Register numbers, all at select 0
    localparam regAddrT regBadVAddr = 5'd8;
    localparam regAddrT regCount    = 5'd9;
    localparam regAddrT regCompare  = 5'd11;
    localparam regAddrT regStatus   = 5'd12;
    localparam regAddrT regCause    = 5'd13;
    localparam regAddrT regEpc      = 5'd14;
    localparam regAddrT regPrid     = 5'd15;
    localparam regAddrT regConfig   = 5'd16;

    // Status field positions
    localparam int statusCu0Bit = 28;
    localparam int statusBevBit = 22;   // Bootstrap vectors
    localparam int statusImLsb  = 8;    // Interrupt mask, 8 bits
    localparam int statusUmBit  = 4;    // User mode
    localparam int statusExlBit = 1;
    localparam int statusIeBit  = 0;

    // Cause field positions
    localparam int causeBdBit  = 31;
    localparam int causeIpLsb  = 8;     // Pending interrupts, 8 bits
    localparam int causeExcLsb = 2;     // ExcCode, 5 bits

    // Exception vectors
    localparam wordT vectorReset         = 32'hBFC0_0000;
    localparam wordT vectorBootGeneral   = 32'hBFC0_0380;   // BEV = 1
    localparam wordT vectorNormalGeneral = 32'h8000_0180;   // BEV = 0

    // Config select 0
    // M set, big endian clear, no MMU, no cache attributes
    localparam wordT configValue = 32'h8000_0000;

endpackage

`default_nettype wire
